/* Bender.yml */
package:
  name: soc_bus

sources:
  - source/soc_bus_pkg.sv
  - source/wb_pri_arbiter.sv
  - source/bus_decoder.sv
  - source/sys_info_regs.sv
  - source/block_ram.sv
  - source/switch_led_port.sv
  - source/soc_bus_top.sv
  - target: simulation
    files:
      - bench/soc_bus_asserts.sv
      - bench/soc_bus_tb.sv

/* bench/soc_bus_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_bus_asserts (
    input logic                 i_clk,
    input logic                 reset,
    input soc_bus_pkg::wb_req_t i_data_req,
    input soc_bus_pkg::wb_req_t i_fetch_req,
    input soc_bus_pkg::wb_req_t i_dbg_req,
    input soc_bus_pkg::wb_rsp_t i_data_rsp,
    input soc_bus_pkg::wb_rsp_t i_fetch_rsp,
    input soc_bus_pkg::wb_rsp_t i_dbg_rsp
);

    import soc_bus_pkg::*;

    // only the ram region, the info region and the led word hold a slave
    function automatic logic unmapped(input logic [WB_ADDR_W-1:0] addr);
        return (addr[REGION_MSB:REGION_LSB] > REGION_INFO) && (addr != SWLED_WORD);
    endfunction

    // ack and err are exclusive on every master port
    assert property (@(posedge i_clk) disable iff (reset)
        !(i_data_rsp.ack && i_data_rsp.err) && !(i_fetch_rsp.ack && i_fetch_rsp.err)
        && !(i_dbg_rsp.ack && i_dbg_rsp.err))
        else $error("ack and err seen in the same cycle");

    // an ack only reaches a master that holds cyc and was not stalled a cycle earlier
    assert property (@(posedge i_clk) disable iff (reset)
        i_data_rsp.ack |-> (i_data_req.cyc && !$past(i_data_rsp.stall)))
        else $error("data port acked while not owning the bus");

    assert property (@(posedge i_clk) disable iff (reset)
        i_fetch_rsp.ack |-> (i_fetch_req.cyc && !$past(i_fetch_rsp.stall)))
        else $error("fetch port acked while not owning the bus");

    assert property (@(posedge i_clk) disable iff (reset)
        i_dbg_rsp.ack |-> (i_dbg_req.cyc && !$past(i_dbg_rsp.stall)))
        else $error("debug port acked while not owning the bus");

    // accepted strobe to an unmapped word is answered by err on the same port
    assert property (@(posedge i_clk) disable iff (reset)
        (i_data_req.cyc && i_data_req.stb && !i_data_rsp.stall && unmapped(i_data_req.addr))
        |=> i_data_rsp.err)
        else $error("unmapped data strobe not answered by err one cycle later");

    assert property (@(posedge i_clk) disable iff (reset)
        (i_fetch_req.cyc && i_fetch_req.stb && !i_fetch_rsp.stall
         && unmapped(i_fetch_req.addr))
        |=> i_fetch_rsp.err)
        else $error("unmapped fetch strobe not answered by err one cycle later");

    assert property (@(posedge i_clk) disable iff (reset)
        (i_dbg_req.cyc && i_dbg_req.stb && !i_dbg_rsp.stall && unmapped(i_dbg_req.addr))
        |=> i_dbg_rsp.err)
        else $error("unmapped debug strobe not answered by err one cycle later");

endmodule

bind soc_bus_top soc_bus_asserts u_asserts (
    .i_clk       (i_clk),
    .reset       (reset),
    .i_data_req  (i_data_req),
    .i_fetch_req (i_fetch_req),
    .i_dbg_req   (i_dbg_req),
    .i_data_rsp  (o_data_rsp),
    .i_fetch_rsp (o_fetch_rsp),
    .i_dbg_rsp   (o_dbg_rsp)
);

`default_nettype wire

/* bench/soc_bus_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_bus_tb;

    import soc_bus_pkg::*;

    localparam int RAM_ADDR_W = 10;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_RAM    = 24;
    localparam int NUM_ERR    = 3;
    localparam int NUM_SWLED  = 4;
    // ram, info block, unmapped plus readback, led port, priority
    localparam int TOTAL_XFERS = 2*NUM_RAM + 13 + 2*NUM_ERR + 2*NUM_SWLED + 3;
    localparam logic [WB_ADDR_W-1:0] INFO_BASE = {REGION_INFO, 21'd0};

    logic        clk;
    logic        reset;
    wb_req_t     req [3];
    wb_rsp_t     rsp [3];
    logic [15:0] switches;
    logic [15:0] leds;
    logic        irq;

    // reference model
    logic [WB_DATA_W-1:0] model_mem [2**RAM_ADDR_W];
    logic [WB_DATA_W-1:0] model_scratch;
    logic                 model_flag;
    logic [15:0]          model_leds;
    logic [WB_ADDR_W-1:0] model_err_addr;

    integer seed;
    int     err_count;
    int     check_count;
    int     test_count;
    int     test_errs;

    soc_bus_top #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) UUT (
        .i_clk       (clk),
        .reset       (reset),
        .i_data_req  (req[0]),
        .i_fetch_req (req[1]),
        .i_dbg_req   (req[2]),
        .o_data_rsp  (rsp[0]),
        .o_fetch_rsp (rsp[1]),
        .o_dbg_rsp   (rsp[2]),
        .i_switches  (switches),
        .o_leds      (leds),
        .o_irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        repeat (200*TOTAL_XFERS) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bus stopped answering",
                 200*TOTAL_XFERS);
        $display("** FAIL **");
        $finish;
    end

    function automatic string rsp_name(input int m);
        case (m)
            0:       return "o_data_rsp";
            1:       return "o_fetch_rsp";
            default: return "o_dbg_rsp";
        endcase
    endfunction

    task automatic check_data(input string name, input logic [WB_DATA_W-1:0] got,
                              input logic [WB_DATA_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_leds(input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t: o_leds = %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_latency(input logic [WB_ADDR_W-1:0] addr, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("access to word %h answered after %0d cycles instead of %0d",
                     addr, got, exp);
        end
    endtask

    // one Wishbone single cycle on master m, latency counted from acceptance
    task automatic bus_cycle(input int m, input logic we, input logic [WB_ADDR_W-1:0] addr,
                             input logic [WB_DATA_W-1:0] wdata, input logic [3:0] sel,
                             output logic [WB_DATA_W-1:0] rdata, output logic got_err,
                             output int lat, output time t_ack);
        wb_req_t r;
        r      = '0;
        r.cyc  = 1'b1;
        r.stb  = 1'b1;
        r.we   = we;
        r.addr = addr;
        r.data = wdata;
        r.sel  = sel;
        @(posedge clk);
        req[m] <= r;
        do begin
            @(negedge clk);
        end while (rsp[m].stall);
        @(posedge clk);
        req[m].stb <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!rsp[m].ack && !rsp[m].err);
        rdata   = rsp[m].data;
        got_err = rsp[m].err;
        t_ack   = $time;
        @(posedge clk);
        req[m] <= '0;
    endtask

    task automatic mapped_access(input int m, input logic we, input logic [WB_ADDR_W-1:0] addr,
                                 input logic [WB_DATA_W-1:0] wdata, input logic [3:0] sel,
                                 input logic [WB_DATA_W-1:0] exp);
        logic [WB_DATA_W-1:0] rdata;
        logic                 got_err;
        int                   lat;
        time                  t_ack;
        bus_cycle(m, we, addr, wdata, sel, rdata, got_err, lat, t_ack);
        check_err({rsp_name(m), ".err"}, got_err, 1'b0);
        check_latency(addr, lat, 2);
        if (!we) begin
            check_data({rsp_name(m), ".data"}, rdata, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-8s finished with %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic ram_test();
        logic [RAM_ADDR_W-1:0] pool [8];
        logic [RAM_ADDR_W-1:0] idx;
        logic [WB_ADDR_W-1:0]  addr;
        logic [WB_DATA_W-1:0]  wdata;
        logic [3:0]            sel;
        logic [31:0]           rnd;
        for (int k = 0; k < 8; k++) begin
            rnd     = $random(seed);
            pool[k] = rnd[RAM_ADDR_W-1:0];
        end
        // first pass fills each pool word on all lanes
        for (int i = 0; i < 2*NUM_RAM; i++) begin
            rnd   = $random(seed);
            idx   = (i < 8) ? pool[i] : pool[{$random(seed)} % 8];
            sel   = (i < 8) ? 4'hf : rnd[3:0];
            wdata = $random(seed);
            rnd   = $random(seed);
            addr  = rnd[WB_ADDR_W-1:0];
            addr[REGION_MSB:REGION_LSB] = REGION_RAM;
            addr[RAM_ADDR_W-1:0]        = idx;
            if (i < NUM_RAM) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
                mapped_access({$random(seed)} % 3, 1'b1, addr, wdata, sel, '0);
            end else begin
                mapped_access({$random(seed)} % 3, 1'b0, addr, '0, 4'hf, model_mem[idx]);
            end
        end
    endtask

    task automatic info_test();
        logic [WB_DATA_W-1:0] wdata;
        logic [WB_DATA_W-1:0] p0;
        logic [WB_DATA_W-1:0] p1;
        logic                 got_err;
        int                   lat;
        time                  t_ack;
        mapped_access(2, 1'b0, INFO_BASE + INFO_OFS_ID, '0, 4'hf, 32'h20191028);
        mapped_access(2, 1'b0, INFO_BASE + INFO_OFS_SCRATCH, '0, 4'hf, model_scratch);
        mapped_access(2, 1'b0, INFO_BASE + INFO_OFS_ERRADDR, '0, 4'hf, {model_err_addr, 2'b00});
        for (int i = 0; i < 2; i++) begin
            wdata         = $random(seed);
            model_scratch = wdata;
            mapped_access(0, 1'b1, INFO_BASE + INFO_OFS_SCRATCH, wdata, 4'hf, '0);
            mapped_access(1, 1'b0, INFO_BASE + INFO_OFS_SCRATCH, '0, 4'hf, model_scratch);
            wdata      = $random(seed);
            model_flag = wdata[0];
            mapped_access(2, 1'b1, INFO_BASE + INFO_OFS_IRQ, wdata, 4'hf, '0);
            mapped_access(0, 1'b0, INFO_BASE + INFO_OFS_IRQ, '0, 4'hf, {31'd0, model_flag});
            check_data("o_irq", {31'd0, irq}, {31'd0, model_flag});
        end
        bus_cycle(1, 1'b0, INFO_BASE + INFO_OFS_POWER, '0, 4'hf, p0, got_err, lat, t_ack);
        bus_cycle(2, 1'b0, INFO_BASE + INFO_OFS_POWER, '0, 4'hf, p1, got_err, lat, t_ack);
        check_count++;
        if (p1 <= p0) begin
            err_count++;
            $display("power counter did not advance between reads (%h then %h)", p0, p1);
        end
    endtask

    task automatic unmapped_test();
        logic [WB_ADDR_W-1:0] addr;
        logic [WB_DATA_W-1:0] rdata;
        logic [31:0]          rnd;
        logic                 got_err;
        int                   lat;
        time                  t_ack;
        int                   m;
        for (int i = 0; i < NUM_ERR; i++) begin
            rnd  = $random(seed);
            addr = rnd[WB_ADDR_W-1:0];
            // regions from 3 upward hold no slave
            addr[REGION_MSB:REGION_LSB] = 9'd3 + ({$random(seed)} % 500);
            m = {$random(seed)} % 3;
            bus_cycle(m, 1'b0, addr, '0, 4'hf, rdata, got_err, lat, t_ack);
            check_err({rsp_name(m), ".err"}, got_err, 1'b1);
            check_latency(addr, lat, 1);
            model_err_addr = addr;
            mapped_access(0, 1'b0, INFO_BASE + INFO_OFS_ERRADDR, '0, 4'hf,
                          {model_err_addr, 2'b00});
        end
    endtask

    task automatic swled_test();
        logic [WB_DATA_W-1:0] wdata;
        logic [15:0]          sw;
        for (int i = 0; i < NUM_SWLED; i++) begin
            wdata      = $random(seed);
            model_leds = wdata[15:0];
            mapped_access({$random(seed)} % 3, 1'b1, SWLED_WORD, wdata, 4'hf, '0);
            @(negedge clk);
            check_leds(leds, model_leds);
            sw = $random(seed);
            @(posedge clk);
            switches <= sw;
            mapped_access({$random(seed)} % 3, 1'b0, SWLED_WORD, '0, 4'hf, {model_leds, sw});
        end
    endtask

    // all three masters start together, data then fetch then debug
    task automatic priority_test();
        logic [WB_ADDR_W-1:0] addr;
        logic [WB_DATA_W-1:0] wdata;
        logic [WB_DATA_W-1:0] rdata [3];
        logic                 got_err [3];
        int                   lat [3];
        time                  t_ack [3];
        time                  t_drop [3];
        logic [31:0]          rnd;
        rnd   = $random(seed);
        addr  = rnd[WB_ADDR_W-1:0];
        addr[REGION_MSB:REGION_LSB] = REGION_RAM;
        wdata = $random(seed);
        model_mem[addr[RAM_ADDR_W-1:0]] = wdata;
        fork
            begin
                bus_cycle(0, 1'b1, addr, wdata, 4'hf, rdata[0], got_err[0], lat[0], t_ack[0]);
                t_drop[0] = $time;
            end
            begin
                bus_cycle(1, 1'b0, addr, '0, 4'hf, rdata[1], got_err[1], lat[1], t_ack[1]);
                t_drop[1] = $time;
            end
            begin
                bus_cycle(2, 1'b0, addr, '0, 4'hf, rdata[2], got_err[2], lat[2], t_ack[2]);
                t_drop[2] = $time;
            end
        join
        for (int m = 0; m < 3; m++) begin
            check_err({rsp_name(m), ".err"}, got_err[m], 1'b0);
        end
        check_data({rsp_name(1), ".data"}, rdata[1], model_mem[addr[RAM_ADDR_W-1:0]]);
        check_data({rsp_name(2), ".data"}, rdata[2], model_mem[addr[RAM_ADDR_W-1:0]]);
        check_count++;
        if (!(t_ack[0] < t_ack[1] && t_ack[2] > t_drop[0] && t_ack[2] > t_drop[1])) begin
            err_count++;
            $display("grant order wrong: acks at %0t, %0t, %0t", t_ack[0], t_ack[1], t_ack[2]);
        end
    endtask

    initial begin
        seed           = 32'h17f0;
        err_count      = 0;
        check_count    = 0;
        test_count     = 0;
        test_errs      = 0;
        model_scratch  = '0;
        model_flag     = 1'b0;
        model_leds     = '0;
        model_err_addr = '0;
        switches       = '0;
        reset          = 1'b1;
        for (int m = 0; m < 3; m++) begin
            req[m] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_leds(leds, 16'h0000);
        check_data("o_irq", {31'd0, irq}, '0);
        for (int m = 0; m < 3; m++) begin
            check_err({rsp_name(m), ".ack"}, rsp[m].ack, 1'b0);
            check_err({rsp_name(m), ".err"}, rsp[m].err, 1'b0);
        end
        end_test("reset");
        ram_test();
        end_test("ram");
        info_test();
        end_test("info");
        unmapped_test();
        end_test("unmapped");
        swled_test();
        end_test("swled");
        priority_test();
        end_test("priority");
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/soc_bus_pkg.sv
source/wb_pri_arbiter.sv
source/bus_decoder.sv
source/sys_info_regs.sv
source/block_ram.sv
source/switch_led_port.sv
source/soc_bus_top.sv
bench/soc_bus_asserts.sv
bench/soc_bus_tb.sv

/* source/block_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module block_ram #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_req,
    output soc_bus_pkg::wb_rsp_t o_rsp
);

    import soc_bus_pkg::*;

    logic [WB_DATA_W-1:0]  mem [2**RAM_ADDR_W];
    logic [RAM_ADDR_W-1:0] word_idx;
    logic [WB_DATA_W-1:0]  rd_data_q;
    logic                  ack_q;

    // addresses above the RAM size alias back into it
    assign word_idx = i_req.addr[RAM_ADDR_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_req.stb) begin
            if (i_req.we) begin
                for (int lane = 0; lane < WB_DATA_W/8; lane++) begin
                    if (i_req.sel[lane]) begin
                        mem[word_idx][lane*8 +: 8] <= i_req.data[lane*8 +: 8];
                    end
                end
            end
            rd_data_q <= mem[word_idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_req.stb;
        end
    end

    assign o_rsp.ack   = ack_q;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.err   = 1'b0;
    assign o_rsp.data  = rd_data_q;

endmodule

`default_nettype wire

/* source/bus_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
    input  logic                                i_clk,
    input  logic                                reset,
    input  soc_bus_pkg::wb_req_t                i_req,
    output soc_bus_pkg::wb_rsp_t                o_rsp,
    output soc_bus_pkg::wb_req_t                o_ram_req,
    output soc_bus_pkg::wb_req_t                o_info_req,
    output soc_bus_pkg::wb_req_t                o_swled_req,
    input  soc_bus_pkg::wb_rsp_t                i_ram_rsp,
    input  soc_bus_pkg::wb_rsp_t                i_info_rsp,
    input  soc_bus_pkg::wb_rsp_t                i_swled_rsp,
    output logic                                o_err_pulse,
    output logic [soc_bus_pkg::WB_ADDR_W-1:0]   o_err_addr
);

    import soc_bus_pkg::*;

    logic ram_sel;
    logic info_sel;
    logic swled_sel;
    logic none_sel;

    logic                 ack_q;
    logic                 err_q;
    logic [WB_DATA_W-1:0] data_q;
    logic [WB_ADDR_W-1:0] err_addr_q;

    assign ram_sel   = (i_req.addr[REGION_MSB:REGION_LSB] == REGION_RAM);
    assign info_sel  = (i_req.addr[REGION_MSB:REGION_LSB] == REGION_INFO);
    assign swled_sel = (i_req.addr == SWLED_WORD);
    assign none_sel  = !ram_sel && !info_sel && !swled_sel;

    // strobe only reaches the selected slave
    always_comb begin
        o_ram_req       = i_req;
        o_ram_req.stb   = i_req.stb && ram_sel;
        o_info_req      = i_req;
        o_info_req.stb  = i_req.stb && info_sel;
        o_swled_req     = i_req;
        o_swled_req.stb = i_req.stb && swled_sel;
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= i_ram_rsp.ack || i_info_rsp.ack || i_swled_rsp.ack;
            err_q <= i_req.stb && none_sel;
        end
    end

    // read data from whichever slave acked
    always_ff @(posedge i_clk) begin
        if (i_ram_rsp.ack) begin
            data_q <= i_ram_rsp.data;
        end else if (i_info_rsp.ack) begin
            data_q <= i_info_rsp.data;
        end else if (i_swled_rsp.ack) begin
            data_q <= i_swled_rsp.data;
        end else begin
            data_q <= '0;
        end
    end

    // address of the unmapped strobe, valid with the err pulse
    always_ff @(posedge i_clk) begin
        if (i_req.stb && none_sel) begin
            err_addr_q <= i_req.addr;
        end
    end

    assign o_rsp.ack   = ack_q;
    assign o_rsp.err   = err_q;
    assign o_rsp.data  = data_q;
    assign o_rsp.stall = (ram_sel && i_ram_rsp.stall)
                      || (info_sel && i_info_rsp.stall)
                      || (swled_sel && i_swled_rsp.stall);

    assign o_err_pulse = err_q;
    assign o_err_addr  = err_addr_q;

endmodule

`default_nettype wire

/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // bus widths, word addressed
    localparam int WB_ADDR_W = 30;
    localparam int WB_DATA_W = 32;

    // master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] addr;
        logic [WB_DATA_W-1:0] data;
        logic [3:0]           sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                 ack;
        logic                 stall;
        logic                 err;
        logic [WB_DATA_W-1:0] data;
    } wb_rsp_t;

    // 8 MB regions picked by the top word-address bits
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 21;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_RAM  = 9'd0;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_INFO = 9'd1;

    // single word, byte address 0x0100_0004
    localparam logic [WB_ADDR_W-1:0] SWLED_WORD = 30'h400001;

    localparam logic [WB_DATA_W-1:0] INFO_ID_VALUE = 32'h20191028;

    // word offsets in the info block, from addr[3:0]
    localparam logic [3:0] INFO_OFS_ID      = 4'h0;
    localparam logic [3:0] INFO_OFS_SCRATCH = 4'h1;
    localparam logic [3:0] INFO_OFS_ERRADDR = 4'h2;
    localparam logic [3:0] INFO_OFS_POWER   = 4'h3;
    localparam logic [3:0] INFO_OFS_IRQ     = 4'h4;

endpackage

`default_nettype wire

/* source/soc_bus_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_bus_top #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_data_req,
    input  soc_bus_pkg::wb_req_t i_fetch_req,
    input  soc_bus_pkg::wb_req_t i_dbg_req,
    output soc_bus_pkg::wb_rsp_t o_data_rsp,
    output soc_bus_pkg::wb_rsp_t o_fetch_rsp,
    output soc_bus_pkg::wb_rsp_t o_dbg_rsp,
    input  logic [15:0]          i_switches,
    output logic [15:0]          o_leds,
    output logic                 o_irq
);

    import soc_bus_pkg::*;

    // data and fetch merge into ibus, ibus and debug into the system bus
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    wb_req_t sys_req;
    wb_rsp_t sys_rsp;

    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t info_req;
    wb_rsp_t info_rsp;
    wb_req_t swled_req;
    wb_rsp_t swled_rsp;

    logic                 err_pulse;
    logic [WB_ADDR_W-1:0] err_addr;

    wb_pri_arbiter u_ibus_arb (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a_req (i_data_req),
        .o_a_rsp (o_data_rsp),
        .i_b_req (i_fetch_req),
        .o_b_rsp (o_fetch_rsp),
        .o_req   (ibus_req),
        .i_rsp   (ibus_rsp)
    );

    wb_pri_arbiter u_sys_arb (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a_req (ibus_req),
        .o_a_rsp (ibus_rsp),
        .i_b_req (i_dbg_req),
        .o_b_rsp (o_dbg_rsp),
        .o_req   (sys_req),
        .i_rsp   (sys_rsp)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .reset       (reset),
        .i_req       (sys_req),
        .o_rsp       (sys_rsp),
        .o_ram_req   (ram_req),
        .o_info_req  (info_req),
        .o_swled_req (swled_req),
        .i_ram_rsp   (ram_rsp),
        .i_info_rsp  (info_rsp),
        .i_swled_rsp (swled_rsp),
        .o_err_pulse (err_pulse),
        .o_err_addr  (err_addr)
    );

    sys_info_regs u_info (
        .i_clk       (i_clk),
        .reset       (reset),
        .i_req       (info_req),
        .o_rsp       (info_rsp),
        .i_err_pulse (err_pulse),
        .i_err_addr  (err_addr),
        .o_irq       (o_irq)
    );

    block_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .i_clk (i_clk),
        .reset (reset),
        .i_req (ram_req),
        .o_rsp (ram_rsp)
    );

    switch_led_port u_swled (
        .i_clk      (i_clk),
        .reset      (reset),
        .i_req      (swled_req),
        .o_rsp      (swled_rsp),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

`default_nettype wire

/* source/switch_led_port.sv */
`timescale 1ns/10ps
`default_nettype none

module switch_led_port (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_req,
    output soc_bus_pkg::wb_rsp_t o_rsp,
    input  logic [15:0]          i_switches,
    output logic [15:0]          o_leds
);

    logic [15:0] leds_q;
    logic [31:0] rd_data_q;
    logic        ack_q;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= i_req.stb;
            if (i_req.stb && i_req.we) begin
                leds_q <= i_req.data[15:0];
            end
        end
    end

    // leds in the upper half, live switches in the lower
    always_ff @(posedge i_clk) begin
        rd_data_q <= {leds_q, i_switches};
    end

    assign o_rsp.ack   = ack_q;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.err   = 1'b0;
    assign o_rsp.data  = rd_data_q;
    assign o_leds      = leds_q;

endmodule

`default_nettype wire

/* source/sys_info_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module sys_info_regs (
    input  logic                              i_clk,
    input  logic                              reset,
    input  soc_bus_pkg::wb_req_t              i_req,
    output soc_bus_pkg::wb_rsp_t              o_rsp,
    input  logic                              i_err_pulse,
    input  logic [soc_bus_pkg::WB_ADDR_W-1:0] i_err_addr,
    output logic                              o_irq
);

    import soc_bus_pkg::*;

    logic [WB_DATA_W-1:0] scratch_q;
    logic [WB_DATA_W-1:0] power_q;
    logic [WB_ADDR_W-1:0] err_addr_q;
    logic                 irq_q;
    logic                 ack_q;
    logic [WB_DATA_W-1:0] rd_data_q;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            scratch_q <= '0;
            irq_q     <= 1'b0;
        end else if (i_req.stb && i_req.we) begin
            case (i_req.addr[3:0])
                INFO_OFS_SCRATCH: scratch_q <= i_req.data;
                INFO_OFS_IRQ:     irq_q     <= i_req.data[0];
                default: begin
                end
            endcase
        end
    end

    // top bit is sticky once reached, lower bits keep wrapping
    always_ff @(posedge i_clk) begin
        if (reset) begin
            power_q <= '0;
        end else begin
            power_q[WB_DATA_W-2:0] <= power_q[WB_DATA_W-2:0] + 1'b1;
            if (&power_q[WB_DATA_W-2:0]) begin
                power_q[WB_DATA_W-1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            err_addr_q <= '0;
        end else if (i_err_pulse) begin
            err_addr_q <= i_err_addr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_req.stb;
        end
    end

    always_ff @(posedge i_clk) begin
        case (i_req.addr[3:0])
            INFO_OFS_ID:      rd_data_q <= INFO_ID_VALUE;
            INFO_OFS_SCRATCH: rd_data_q <= scratch_q;
            INFO_OFS_ERRADDR: rd_data_q <= {err_addr_q, 2'b00};
            INFO_OFS_POWER:   rd_data_q <= power_q;
            INFO_OFS_IRQ:     rd_data_q <= {{(WB_DATA_W-1){1'b0}}, irq_q};
            default:          rd_data_q <= '0;
        endcase
    end

    assign o_rsp.ack   = ack_q;
    assign o_rsp.stall = 1'b0;
    assign o_rsp.err   = 1'b0;
    assign o_rsp.data  = rd_data_q;
    assign o_irq       = irq_q;

endmodule

`default_nettype wire

/* source/wb_pri_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_pri_arbiter (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_a_req,
    output soc_bus_pkg::wb_rsp_t o_a_rsp,
    input  soc_bus_pkg::wb_req_t i_b_req,
    output soc_bus_pkg::wb_rsp_t o_b_rsp,
    output soc_bus_pkg::wb_req_t o_req,
    input  soc_bus_pkg::wb_rsp_t i_rsp
);

    // 0: A owns the bus, 1: B owns it
    logic b_owner;
    logic owner_cyc;

    assign owner_cyc = b_owner ? i_b_req.cyc : i_a_req.cyc;

    // ownership only changes between cycles
    // an idle bus falls back to A, so A wins a simultaneous start
    always_ff @(posedge i_clk) begin
        if (reset) begin
            b_owner <= 1'b0;
        end else if (!owner_cyc) begin
            b_owner <= i_b_req.cyc && !i_a_req.cyc;
        end
    end

    always_comb begin
        o_req = b_owner ? i_b_req : i_a_req;
        // merged cyc stays up across a handover between A and B,
        // so an upstream arbiter does not see a gap and switch away
        o_req.cyc = i_a_req.cyc || i_b_req.cyc;
    end

    // owner gets the response, the other one just sees stall
    always_comb begin
        o_a_rsp.ack   = i_rsp.ack && !b_owner;
        o_a_rsp.err   = i_rsp.err && !b_owner;
        o_a_rsp.stall = i_rsp.stall || b_owner;
        o_a_rsp.data  = i_rsp.data;

        o_b_rsp.ack   = i_rsp.ack && b_owner;
        o_b_rsp.err   = i_rsp.err && b_owner;
        o_b_rsp.stall = i_rsp.stall || !b_owner;
        o_b_rsp.data  = i_rsp.data;
    end

endmodule

`default_nettype wire
